// ==== rtl/mac_pe.sv ====
module mac_pe (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          act_valid,
    input  mcast_pkg::data_view_t         act_data,
    input  logic                          first_in_window,
    output logic                          act_ready,
    input  logic [mcast_pkg::ksize_w-1:0] kernel_size,
    output logic [mcast_pkg::ksize_w-1:0] rd_pos,
    input  logic [mcast_pkg::data_w-1:0]  rd_data,
    output logic                          sum_valid,
    output logic [mcast_pkg::psum_w-1:0]  sum,
    input  logic                          sum_ready
);

    logic                                  act_take;
    logic                                  is_last;
    logic [mcast_pkg::ksize_w-1:0]         pos;
    logic signed [2*mcast_pkg::data_w-1:0] prod;
    logic signed [mcast_pkg::psum_w-1:0]   seed;
    logic signed [mcast_pkg::psum_w-1:0]   acc;
    logic signed [mcast_pkg::psum_w-1:0]   acc_next;

    ////////////////////
    // window position
    ////////////////////

    // first word restarts the window, also after a reload
    assign rd_pos  = first_in_window ? '0 : pos;
    assign is_last = (rd_pos == kernel_size - mcast_pkg::ksize_w'(1));

    // stall only while a finished sum is still stuck here
    assign act_ready = !sum_valid || sum_ready;
    assign act_take  = act_valid && act_ready;

    ////////////////////
    // multiply-accumulate
    ////////////////////

    assign prod = $signed(act_data.value) * $signed(rd_data);

    // psum from the bus seeds the window
    assign seed     = first_in_window ? $signed(act_data.psum_in) : acc;
    assign acc_next = seed + mcast_pkg::psum_w'(prod);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pos       <= '0;
            sum_valid <= 1'b0;
        end else begin
            if (act_take) begin
                pos <= is_last ? '0 : rd_pos + mcast_pkg::ksize_w'(1);
            end
            // new sum wins over the drain
            if (act_take && is_last) begin
                sum_valid <= 1'b1;
            end else if (sum_ready) begin
                sum_valid <= 1'b0;
            end
        end
    end

    // accumulator and finished sum
    always_ff @(posedge clk) begin
        if (act_take) begin
            acc <= acc_next;
            if (is_last) begin
                sum <= acc_next;
            end
        end
    end

endmodule

// ==== rtl/mcast_pkg.sv ====
package mcast_pkg;

    ////////////////////
    // widths
    ////////////////////

    // activation and weight width
    localparam int data_w = 16;
    // partial sum width, holds a full product
    localparam int psum_w = 32;
    // column id / tag width
    localparam int tag_w = 4;
    // kernel_size field width
    localparam int ksize_w = 8;
    // bus payload, one value plus one psum
    localparam int payload_w = data_w + psum_w;

    ////////////////////
    // word kinds
    ////////////////////

    // 2'd3 unused, dropped by the decode stage
    typedef enum logic [1:0] {
        kind_cfg = 2'd0,
        kind_wgt = 2'd1,
        kind_act = 2'd2
    } word_kind_e;

    ////////////////////
    // payload views
    ////////////////////

    // configuration view
    typedef struct packed {
        logic [ksize_w-1:0]           kernel_size;
        logic [payload_w-ksize_w-1:0] pad;
    } cfg_view_t;

    // data view, value is a weight or an activation
    // psum_in only meaningful on the first activation of a window
    typedef struct packed {
        logic [data_w-1:0] value;
        logic [psum_w-1:0] psum_in;
    } data_view_t;

    // one payload, decoded by kind
    typedef union packed {
        cfg_view_t  cfg;
        data_view_t data;
    } bus_payload_u;

    // full bus word
    typedef struct packed {
        word_kind_e   kind;
        logic [tag_w-1:0] id;
        bus_payload_u payload;
    } bus_word_t;

    // finished window back to the bus
    typedef struct packed {
        logic [tag_w-1:0]  tag;
        logic [psum_w-1:0] psum;
    } psum_result_t;

endpackage

// ==== rtl/multicaster_top.sv ====
module multicaster_top #(
    parameter int BUFFER_DEPTH = 16
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        bus_valid,
    input  mcast_pkg::bus_word_t        bus_word,
    output logic                        bus_ready,
    input  logic [mcast_pkg::tag_w-1:0] col_tag,
    output logic                        tag_lock,
    output logic                        res_valid,
    output mcast_pkg::psum_result_t     res,
    input  logic                        res_ready
);

    ////////////////////
    // stage links
    ////////////////////

    logic [mcast_pkg::tag_w-1:0]   tag;
    logic                          cfg_load;
    logic [mcast_pkg::ksize_w-1:0] kernel_size;
    logic                          wgt_wr;
    logic [mcast_pkg::data_w-1:0]  wgt_data;
    logic                          wgt_loaded;
    // activation handshake
    logic                          act_valid;
    logic                          act_ready;
    mcast_pkg::data_view_t         act_data;
    logic                          first_in_window;
    // weight read port
    logic [mcast_pkg::ksize_w-1:0] rd_pos;
    logic [mcast_pkg::data_w-1:0]  rd_data;
    // finished window
    logic                          sum_valid;
    logic                          sum_ready;
    logic [mcast_pkg::psum_w-1:0]  sum;

    // decode
    tag_filter u_tag_filter (
        .clk             (clk),
        .rstn            (rstn),
        .bus_valid       (bus_valid),
        .bus_word        (bus_word),
        .bus_ready       (bus_ready),
        .col_tag         (col_tag),
        .tag             (tag),
        .tag_lock        (tag_lock),
        .wgt_loaded      (wgt_loaded),
        .cfg_load        (cfg_load),
        .kernel_size     (kernel_size),
        .wgt_wr          (wgt_wr),
        .wgt_data        (wgt_data),
        .act_valid       (act_valid),
        .act_data        (act_data),
        .first_in_window (first_in_window),
        .act_ready       (act_ready)
    );

    // filter taps
    weight_buff #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) u_weight_buff (
        .clk         (clk),
        .rstn        (rstn),
        .cfg_load    (cfg_load),
        .kernel_size (kernel_size),
        .wgt_wr      (wgt_wr),
        .wgt_data    (wgt_data),
        .loaded      (wgt_loaded),
        .rd_pos      (rd_pos),
        .rd_data     (rd_data)
    );

    // execute
    mac_pe u_mac_pe (
        .clk             (clk),
        .rstn            (rstn),
        .act_valid       (act_valid),
        .act_data        (act_data),
        .first_in_window (first_in_window),
        .act_ready       (act_ready),
        .kernel_size     (kernel_size),
        .rd_pos          (rd_pos),
        .rd_data         (rd_data),
        .sum_valid       (sum_valid),
        .sum             (sum),
        .sum_ready       (sum_ready)
    );

    // result
    psum_return u_psum_return (
        .clk       (clk),
        .rstn      (rstn),
        .sum_valid (sum_valid),
        .sum       (sum),
        .sum_ready (sum_ready),
        .tag       (tag),
        .res_valid (res_valid),
        .res       (res),
        .res_ready (res_ready)
    );

endmodule

// ==== rtl/psum_return.sv ====
module psum_return (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         sum_valid,
    input  logic [mcast_pkg::psum_w-1:0] sum,
    output logic                         sum_ready,
    input  logic [mcast_pkg::tag_w-1:0]  tag,
    output logic                         res_valid,
    output mcast_pkg::psum_result_t      res,
    input  logic                         res_ready
);

    logic sum_take;

    // one entry, refill on the cycle it drains
    assign sum_ready = !res_valid || res_ready;
    assign sum_take  = sum_valid && sum_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            res_valid <= 1'b0;
        end else if (sum_take) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    // stamp with the locked column tag
    always_ff @(posedge clk) begin
        if (sum_take) begin
            res.tag  <= tag;
            res.psum <= sum;
        end
    end

    // pending result held for the bus
    a_res_stable: assert property (@(posedge clk) disable iff (!rstn)
        res_valid && !res_ready |=> res_valid && $stable(res));

endmodule

// ==== rtl/tag_filter.sv ====
module tag_filter (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          bus_valid,
    input  mcast_pkg::bus_word_t          bus_word,
    output logic                          bus_ready,
    input  logic [mcast_pkg::tag_w-1:0]   col_tag,
    output logic [mcast_pkg::tag_w-1:0]   tag,
    output logic                          tag_lock,
    input  logic                          wgt_loaded,
    output logic                          cfg_load,
    output logic [mcast_pkg::ksize_w-1:0] kernel_size,
    output logic                          wgt_wr,
    output logic [mcast_pkg::data_w-1:0]  wgt_data,
    output logic                          act_valid,
    output mcast_pkg::data_view_t         act_data,
    output logic                          first_in_window,
    input  logic                          act_ready
);

    logic                          is_cfg;
    logic                          is_wgt;
    logic                          is_act;
    logic                          id_match;
    logic                          act_free;
    logic                          cfg_take;
    logic                          wgt_take;
    logic                          act_take;
    logic [mcast_pkg::ksize_w-1:0] act_cnt;

    ////////////////////
    // decode
    ////////////////////

    assign is_cfg = (bus_word.kind == mcast_pkg::kind_cfg);
    assign is_wgt = (bus_word.kind == mcast_pkg::kind_wgt);
    assign is_act = (bus_word.kind == mcast_pkg::kind_act);

    // nothing matches before the first config
    assign id_match = tag_lock && (bus_word.id == tag);

    // activation stage empty or draining this cycle
    assign act_free = !act_valid || act_ready;

    always_comb begin
        // config and foreign words always taken
        bus_ready = 1'b1;
        if (id_match) begin
            if (is_wgt) begin
                // one weight in flight at a time
                bus_ready = !wgt_loaded && !wgt_wr;
            end else if (is_act) begin
                // loaded flag is stale while cfg_load is pending
                bus_ready = wgt_loaded && !cfg_load && act_free;
            end
        end
    end

    assign cfg_take = bus_valid && bus_ready && is_cfg;
    assign wgt_take = bus_valid && bus_ready && is_wgt && id_match;
    assign act_take = bus_valid && bus_ready && is_act && id_match;

    ////////////////////
    // control state
    ////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tag             <= '0;
            tag_lock        <= 1'b0;
            kernel_size     <= '0;
            cfg_load        <= 1'b0;
            wgt_wr          <= 1'b0;
            act_valid       <= 1'b0;
            act_cnt         <= '0;
            first_in_window <= 1'b0;
        end else begin
            cfg_load <= cfg_take;
            wgt_wr   <= wgt_take;
            if (cfg_take) begin
                // tag comes from the port, not the bus
                tag         <= col_tag;
                tag_lock    <= 1'b1;
                kernel_size <= bus_word.payload.cfg.kernel_size;
                act_cnt     <= '0;
            end
            if (act_take) begin
                act_valid       <= 1'b1;
                first_in_window <= (act_cnt == '0);
                // wrap at window end
                if (act_cnt == kernel_size - mcast_pkg::ksize_w'(1)) begin
                    act_cnt <= '0;
                end else begin
                    act_cnt <= act_cnt + mcast_pkg::ksize_w'(1);
                end
            end else if (act_ready) begin
                act_valid <= 1'b0;
            end
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (wgt_take) begin
            wgt_data <= bus_word.payload.data.value;
        end
        if (act_take) begin
            act_data <= bus_word.payload.data;
        end
    end

    // held activation is not withdrawn or changed before mac_pe takes it
    a_act_hold: assert property (@(posedge clk) disable iff (!rstn)
        act_valid && !act_ready |=> act_valid && $stable(act_data)
        && $stable(first_in_window));

endmodule

// ==== rtl/weight_buff.sv ====
module weight_buff #(
    parameter int BUFFER_DEPTH = 16
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          cfg_load,
    input  logic [mcast_pkg::ksize_w-1:0] kernel_size,
    input  logic                          wgt_wr,
    input  logic [mcast_pkg::data_w-1:0]  wgt_data,
    output logic                          loaded,
    input  logic [mcast_pkg::ksize_w-1:0] rd_pos,
    output logic [mcast_pkg::data_w-1:0]  rd_data
);

    localparam int addr_w = $clog2(BUFFER_DEPTH);

    // filter taps for the current window
    logic [mcast_pkg::data_w-1:0]  mem [BUFFER_DEPTH];
    logic [mcast_pkg::ksize_w-1:0] wr_ptr;
    logic [mcast_pkg::ksize_w-1:0] wr_ptr_next;

    assign wr_ptr_next = wr_ptr + mcast_pkg::ksize_w'(1);

    ////////////////////
    // write side
    ////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            loaded <= 1'b0;
        end else if (cfg_load) begin
            // new kernel, start over
            wr_ptr <= '0;
            loaded <= 1'b0;
        end else if (wgt_wr) begin
            wr_ptr <= wr_ptr_next;
            // last tap written on this edge
            if (wr_ptr_next == kernel_size) begin
                loaded <= 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (wgt_wr) begin
            mem[wr_ptr[addr_w-1:0]] <= wgt_data;
        end
    end

    ////////////////////
    // read side
    ////////////////////

    // window position from mac_pe, no latency
    assign rd_data = mem[rd_pos[addr_w-1:0]];

    // tag_filter must stop weights once the window is full
    a_no_wr_loaded: assert property (@(posedge clk) disable iff (!rstn)
        wgt_wr |-> !loaded);

    // kernel must fit the buffer
    a_ksize_fits: assert property (@(posedge clk) disable iff (!rstn)
        cfg_load |-> (kernel_size != '0) && (int'(kernel_size) <= BUFFER_DEPTH));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the multicaster testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module multicaster_tb \
    -f tb.f \
    -o sim_multicaster

./obj_dir/sim_multicaster 2>&1 | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without failures"
exit 0

// ==== tb.f ====
rtl/mcast_pkg.sv
rtl/tag_filter.sv
rtl/weight_buff.sv
rtl/mac_pe.sv
rtl/psum_return.sv
rtl/multicaster_top.sv
verif/tb_clk_gen.sv
verif/multicaster_tb.sv

// ==== verif/multicaster_tb.sv ====
module multicaster_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int buffer_depth = 16;
    // phase table, kernel size and window count
    localparam int ks_a = 3;
    localparam int nwin_a = 5;
    localparam int ks_b = 9;
    localparam int nwin_b = 3;
    localparam int ks_c = 5;
    localparam int nwin_c = 4;

    logic                        clk;
    logic                        rstn;
    logic                        bus_valid;
    mcast_pkg::bus_word_t        bus_word;
    logic                        bus_ready;
    logic [mcast_pkg::tag_w-1:0] col_tag;
    logic                        tag_lock;
    logic                        res_valid;
    mcast_pkg::psum_result_t     res;
    logic                        res_ready;

    // stimulus side view of the slot
    logic [mcast_pkg::tag_w-1:0]   cur_tag;
    logic [mcast_pkg::ksize_w-1:0] cur_ksize;
    logic                          foreign_on;
    int                            ready_pct;
    string                         test_name;
    int                            windows_sent;
    mcast_pkg::psum_result_t       exp_q [$];

    // monitor state
    logic                    took;
    int                      wgt_seen;
    logic                    exp_loaded;
    logic                    held_on;
    mcast_pkg::psum_result_t held_res;
    int                      results_got = 0;
    int                      early_hits = 0;
    int                      value_errs = 0;
    int                      proto_errs = 0;

    tb_clk_gen u_clk_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    multicaster_top #(
        .BUFFER_DEPTH (buffer_depth)
    ) DUT (
        .clk       (clk),
        .rstn      (rstn),
        .bus_valid (bus_valid),
        .bus_word  (bus_word),
        .bus_ready (bus_ready),
        .col_tag   (col_tag),
        .tag_lock  (tag_lock),
        .res_valid (res_valid),
        .res       (res),
        .res_ready (res_ready)
    );

    // config, foreign weight, weights, then each window plus one foreign activation
    function automatic int phase_words(input int ks, input int nwin);
        return 2 + ks + nwin * (ks + 1);
    endfunction

    ////////////////////
    // bus driver
    ////////////////////

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_word(input mcast_pkg::bus_word_t word);
        bus_valid = 1'b1;
        bus_word  = word;
        do begin
            @(posedge clk);
            @(negedge clk);
        end while (!took);
        bus_valid = 1'b0;
    endtask

    // word for some other column
    task automatic send_foreign(input mcast_pkg::word_kind_e kind);
        mcast_pkg::bus_word_t word;
        word                      = '0;
        word.kind                 = kind;
        word.id                   = cur_tag ^ mcast_pkg::tag_w'($urandom_range(15, 1));
        word.payload.data.value   = mcast_pkg::data_w'($urandom);
        word.payload.data.psum_in = mcast_pkg::psum_w'($urandom);
        foreign_on = 1'b1;
        send_word(word);
        foreign_on = 1'b0;
    endtask

    // config, weights, then nwin windows; expected sums queued per window
    task automatic run_phase(input string name, input int ks, input int nwin,
                             input int pct, input logic [mcast_pkg::tag_w-1:0] tagv);
        logic signed [mcast_pkg::data_w-1:0] w [buffer_depth];
        logic signed [mcast_pkg::data_w-1:0] a [buffer_depth];
        logic signed [mcast_pkg::psum_w-1:0] seed;
        logic signed [mcast_pkg::psum_w-1:0] acc;
        mcast_pkg::bus_word_t                word;
        mcast_pkg::psum_result_t             want;
        test_name = name;
        ready_pct = pct;
        col_tag   = tagv;
        cur_tag   = tagv;
        cur_ksize = mcast_pkg::ksize_w'(ks);
        word      = '0;
        word.kind = mcast_pkg::kind_cfg;
        // id of a config word means nothing
        word.id   = mcast_pkg::tag_w'($urandom);
        word.payload.cfg.kernel_size = mcast_pkg::ksize_w'(ks);
        send_word(word);
        // port moves on, the locked tag must not
        col_tag = ~tagv;
        send_foreign(mcast_pkg::kind_wgt);
        for (int i = 0; i < ks; i++) begin
            w[i]      = mcast_pkg::data_w'($urandom);
            word      = '0;
            word.kind = mcast_pkg::kind_wgt;
            word.id   = tagv;
            word.payload.data.value   = w[i];
            word.payload.data.psum_in = mcast_pkg::psum_w'($urandom);
            send_word(word);
        end
        // first activation follows the last weight with no gap
        for (int n = 0; n < nwin; n++) begin
            seed = mcast_pkg::psum_w'($urandom);
            acc  = seed;
            for (int j = 0; j < ks; j++) begin
                a[j] = mcast_pkg::data_w'($urandom);
                acc  = acc + mcast_pkg::psum_w'(w[j]) * mcast_pkg::psum_w'(a[j]);
            end
            want.tag  = tagv;
            want.psum = acc;
            exp_q.push_back(want);
            windows_sent++;
            for (int j = 0; j < ks; j++) begin
                word      = '0;
                word.kind = mcast_pkg::kind_act;
                word.id   = tagv;
                word.payload.data.value = a[j];
                // junk psum on later words, only the first one seeds
                word.payload.data.psum_in = (j == 0) ? seed : mcast_pkg::psum_w'($urandom);
                send_word(word);
                if (j == 0) begin
                    send_foreign(mcast_pkg::kind_act);
                end
            end
            repeat ($urandom_range(2)) @(negedge clk);
        end
        // drain before the next reload
        wait (results_got >= windows_sent);
        @(negedge clk);
    endtask

    ////////////////////
    // monitor
    ////////////////////

    always @(posedge clk or negedge rstn) begin
        mcast_pkg::psum_result_t want;
        if (!rstn) begin
            took       <= 1'b0;
            wgt_seen   <= 0;
            exp_loaded <= 1'b0;
            held_on    <= 1'b0;
        end else begin
            took <= bus_valid && bus_ready;
            if (bus_valid && bus_ready && bus_word.kind == mcast_pkg::kind_cfg) begin
                wgt_seen <= 0;
            end else if (bus_valid && bus_ready && bus_word.kind == mcast_pkg::kind_wgt
                         && bus_word.id == cur_tag) begin
                wgt_seen <= wgt_seen + 1;
            end
            // buffer full one edge after the last weight is taken
            exp_loaded <= (wgt_seen == int'(cur_ksize))
                          && !(bus_valid && bus_ready && bus_word.kind == mcast_pkg::kind_cfg);
            if (bus_valid && bus_word.kind == mcast_pkg::kind_act && bus_word.id == cur_tag
                && !foreign_on && !exp_loaded) begin
                early_hits++;
            end
            // pending result must sit still
            held_on  <= res_valid && !res_ready;
            held_res <= res;
            if (held_on) begin
                assert (res_valid && res == held_res) else begin
                    value_errs++;
                    $display("[FAIL] %s hold: expected %h, actual %h", test_name, held_res, res);
                end
            end
            if (res_valid && res_ready) begin
                results_got++;
                if (exp_q.size() == 0) begin
                    proto_errs++;
                    $display("result came out with no window left to match it");
                end else begin
                    want = exp_q.pop_front();
                    assert (res.psum == want.psum) else begin
                        value_errs++;
                        $display("[FAIL] %s psum: expected %0d, actual %0d", test_name,
                                 $signed(want.psum), $signed(res.psum));
                    end
                    assert (res.tag == want.tag) else begin
                        value_errs++;
                        $display("[FAIL] %s tag: expected %0h, actual %0h", test_name,
                                 want.tag, res.tag);
                    end
                end
            end
        end
    end

    ////////////////////
    // bus rules
    ////////////////////

    a_cfg_ready: assert property (@(posedge clk) disable iff (!rstn)
        bus_valid && bus_word.kind == mcast_pkg::kind_cfg |-> bus_ready)
        else begin
            proto_errs++;
            $display("config word was held off by bus_ready");
        end

    a_lock: assert property (@(posedge clk) disable iff (!rstn)
        bus_valid && bus_ready && bus_word.kind == mcast_pkg::kind_cfg |=> tag_lock)
        else begin
            proto_errs++;
            $display("tag_lock did not rise after a config word");
        end

    a_foreign: assert property (@(posedge clk) disable iff (!rstn)
        bus_valid && foreign_on |-> bus_ready)
        else begin
            proto_errs++;
            $display("word for another column was not accepted");
        end

    a_early_act: assert property (@(posedge clk) disable iff (!rstn)
        bus_valid && bus_word.kind == mcast_pkg::kind_act && bus_word.id == cur_tag
        && !foreign_on && !exp_loaded |-> !bus_ready)
        else begin
            proto_errs++;
            $display("activation accepted before the weights were loaded");
        end

    ////////////////////
    // stimulus
    ////////////////////

    // back-pressure on the result port
    initial begin
        res_ready = 1'b0;
        forever begin
            @(negedge clk);
            res_ready = ($urandom_range(99) < ready_pct);
        end
    end

    initial begin
        int late_errs;
        late_errs = 0;
        void'($urandom(32'ha342));
        bus_valid    = 1'b0;
        bus_word     = '0;
        col_tag      = '0;
        cur_tag      = '0;
        cur_ksize    = '0;
        foreign_on   = 1'b0;
        ready_pct    = 100;
        test_name    = "reset";
        windows_sent = 0;
        @(posedge rstn);
        @(negedge clk);
        run_phase("ks3_tag5", ks_a, nwin_a, 100, 4'h5);
        run_phase("ks9_backpressure", ks_b, nwin_b, 50, 4'hc);
        run_phase("reload_ks5", ks_c, nwin_c, 40, 4'h3);
        // quiet tail, anything arriving now is spurious
        repeat (20) @(negedge clk);
        if (early_hits == 0) begin
            late_errs++;
            $display("no activation was ever presented ahead of its weights");
        end
        if (results_got != windows_sent) begin
            late_errs++;
            $display("got %0d results for %0d windows", results_got, windows_sent);
        end
        $display("errors: %0d value, %0d protocol, %0d end of run",
                 value_errs, proto_errs, late_errs);
        if (value_errs + proto_errs + late_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // watchdog, 8 cycles per word plus slack
    initial begin
        int limit;
        limit = (phase_words(ks_a, nwin_a) + phase_words(ks_b, nwin_b)
                 + phase_words(ks_c, nwin_c)) * 8 + 200;
        repeat (limit) @(posedge clk);
        $display("run did not finish within %0d cycles", limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== verif/tb_clk_gen.sv ====
module tb_clk_gen (
    output logic clk,
    output logic rstn
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int reset_cycles = 10;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset released on a falling edge, away from the sampling edge
    initial begin
        rstn = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule
